//--- lumi_pkg.sv
// LUMI transmit shared definitions
// UMI field widths and the packet layout used for serialization,
// opcode constants, byte and credit counter types
package lumi_pkg;

   // ########################################
   // UMI field widths
   // ########################################
   localparam int cmd_w  = 32;
   localparam int addr_w = 64;
   localparam int data_w = 128;

   typedef logic [cmd_w-1:0]  umi_cmd_t;   // [4:0] opcode, [7:5] size, [15:8] len
   typedef logic [addr_w-1:0] umi_addr_t;  // Source or destination address
   typedef logic [data_w-1:0] umi_data_t;  // Payload

   // Serialization order, cmd in the low bits leaves first
   typedef struct packed {
      umi_data_t data;
      umi_addr_t srcaddr;
      umi_addr_t dstaddr;
      umi_cmd_t  cmd;
   } umi_pkt_t;

   // ########################################
   // Packet byte counts
   // ########################################
   localparam int cmd_bytes = cmd_w / 8;                 // 4
   localparam int hdr_bytes = (cmd_w + 2 * addr_w) / 8;  // 20, cmd plus both addresses
   localparam int pkt_bytes = $bits(umi_pkt_t) / 8;      // 36

   typedef logic [11:0]          byte_cnt_t;   // Bytes in one packet
   typedef logic [pkt_bytes-1:0] byte_mask_t;  // One valid bit per packet byte

   // Credits and beats
   typedef logic [15:0] crdt_t;      // Credit limit or counter, wraps
   typedef logic [7:0]  beat_cnt_t;  // PHY beats of one packet

   // ########################################
   // Opcodes
   // ########################################
   localparam logic [4:0] op_invalid    = 5'd0;
   localparam logic [4:0] op_req_read   = 5'd1;
   localparam logic [4:0] op_req_write  = 5'd3;
   localparam logic [4:0] op_req_posted = 5'd5;
   localparam logic [4:0] op_req_rdma   = 5'd7;
   localparam logic [4:0] op_resp_read  = 5'd8;
   localparam logic [4:0] op_resp_write = 5'd9;
   localparam logic [4:0] op_user0      = 5'd12;
   localparam logic [4:0] op_error      = 5'd13;
   localparam logic [4:0] op_link       = 5'd15;

endpackage

//--- lumi_cmd_decode.sv
// LUMI command decode
// Classifies one channel's opcode as command only, header only or full,
// and works out the bytes the packet needs on the wire and the number of
// PHY beats it takes, which is also its credit cost
module lumi_cmd_decode
  #(parameter int io_w = 64)  // PHY width in bits
   (input  lumi_pkg::umi_cmd_t  cmd,        // Command word of the channel
    output lumi_pkg::byte_cnt_t pkt_bytes,  // Bytes on the wire
    output lumi_pkg::beat_cnt_t beats       // PHY beats, credit cost
    );

   localparam int beat_bytes = io_w / 8;              // Bytes per beat
   localparam int data_max   = lumi_pkg::data_w / 8;  // Payload saturates here

   logic [4:0]          opcode;
   logic [2:0]          size;
   logic [7:0]          len;
   logic                cmd_only;    // Just the command word
   logic                hdr_only;    // Command plus addresses
   logic [15:0]         data_raw;    // (len+1) << size, before saturation
   lumi_pkg::byte_cnt_t data_bytes;

   // Command fields
   assign opcode = cmd[4:0];
   assign size   = cmd[7:5];
   assign len    = cmd[15:8];

   // ########################################
   // Packet class
   // ########################################
   always_comb
   begin
      cmd_only = 1'b0;
      hdr_only = 1'b0;
      case (opcode)
         lumi_pkg::op_invalid,
         lumi_pkg::op_link:       cmd_only = 1'b1;
         lumi_pkg::op_req_read,
         lumi_pkg::op_req_rdma,
         lumi_pkg::op_resp_write,
         lumi_pkg::op_user0,
         lumi_pkg::op_error:      hdr_only = 1'b1;
         default:                 ;  // Full packet with payload
      endcase
   end

   // Payload size, a 256 x 128 request still fits in 16 bits
   assign data_raw   = (16'(len) + 16'd1) << size;
   assign data_bytes = (data_raw > 16'(data_max)) ? lumi_pkg::byte_cnt_t'(data_max)
                                                  : data_raw[11:0];

   // ########################################
   // Byte and beat count
   // ########################################
   always_comb
   begin
      if (cmd_only)
         pkt_bytes = lumi_pkg::byte_cnt_t'(lumi_pkg::cmd_bytes);
      else if (hdr_only)
         pkt_bytes = lumi_pkg::byte_cnt_t'(lumi_pkg::hdr_bytes);
      else
         pkt_bytes = lumi_pkg::byte_cnt_t'(lumi_pkg::hdr_bytes) + data_bytes;
   end

   // Round up to whole beats
   assign beats = lumi_pkg::beat_cnt_t'((pkt_bytes + lumi_pkg::byte_cnt_t'(beat_bytes - 1))
                                        / lumi_pkg::byte_cnt_t'(beat_bytes));

endmodule

//--- lumi_tx_credit.sv
// LUMI transmit credit tracking
// Counts the beats sent on each channel against the limits the remote
// receiver advertises, flags whether a channel's next packet fits, and
// counts the cycles a valid channel waits for credit
module lumi_tx_credit
  #(parameter int io_w = 64)  // PHY width in bits
   (input                       clk,
    input                       nreset,
    input  lumi_pkg::crdt_t     rmt_crdt_req,   // Remote request limit
    input  lumi_pkg::crdt_t     rmt_crdt_resp,  // Remote response limit
    input  lumi_pkg::beat_cnt_t req_beats,      // Cost of pending request
    input  lumi_pkg::beat_cnt_t resp_beats,     // Cost of pending response
    input                       req_valid,
    input                       resp_valid,
    input                       phy_txrdy,
    input                       phy_txvld,      // Beat on the PHY this cycle
    input                       beat_resp,      // Beat belongs to a response
    output logic                req_crdt_ok,
    output logic                resp_crdt_ok,
    output logic [31:0]         crdt_status     // {resp stalls, req stalls}
    );

   // Beats of the largest packet
   localparam int max_beats = (lumi_pkg::pkt_bytes * 8 + io_w - 1) / io_w;

   lumi_pkg::crdt_t sent_req;     // Request beats sent, wraps
   lumi_pkg::crdt_t sent_resp;    // Response beats sent, wraps
   lumi_pkg::crdt_t req_avail;
   lumi_pkg::crdt_t resp_avail;
   lumi_pkg::crdt_t stall_req;
   lumi_pkg::crdt_t stall_resp;
   logic            req_beat;
   logic            resp_beat;

   assign req_beat  = phy_txvld & ~beat_resp;
   assign resp_beat = phy_txvld & beat_resp;

   // ########################################
   // Sent beat counters
   // ########################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         sent_req  <= '0;
         sent_resp <= '0;
      end
      else
      begin
         sent_req  <= sent_req + lumi_pkg::crdt_t'(req_beat);
         sent_resp <= sent_resp + lumi_pkg::crdt_t'(resp_beat);
      end

   // Remaining credit, the beat on the wire is not counted yet
   assign req_avail    = rmt_crdt_req - sent_req - lumi_pkg::crdt_t'(req_beat);
   assign resp_avail   = rmt_crdt_resp - sent_resp - lumi_pkg::crdt_t'(resp_beat);
   assign req_crdt_ok  = req_avail >= lumi_pkg::crdt_t'(req_beats);
   assign resp_crdt_ok = resp_avail >= lumi_pkg::crdt_t'(resp_beats);

   // ########################################
   // No-credit stall counters
   // ########################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         stall_req  <= '0;
         stall_resp <= '0;
      end
      else
      begin
         stall_req  <= stall_req + lumi_pkg::crdt_t'(req_valid & phy_txrdy & ~req_crdt_ok);
         stall_resp <= stall_resp + lumi_pkg::crdt_t'(resp_valid & phy_txrdy & ~resp_crdt_ok);
      end

   assign crdt_status = {stall_resp, stall_req};

   // Every beat on the wire still had a credit behind it
   a_crdt_limit: assert property (@(posedge clk) disable iff (!nreset)
      (req_beat |-> sent_req != rmt_crdt_req) and (resp_beat |-> sent_resp != rmt_crdt_resp))
      else $error("credit: sent beats passed the remote limit");

   // Decoded cost stays within one full packet
   a_beat_cost: assert property (@(posedge clk) disable iff (!nreset)
      (req_valid |-> req_beats <= max_beats) and (resp_valid |-> resp_beats <= max_beats))
      else $error("credit: packet cost exceeds %0d beats", max_beats);

endmodule

//--- lumi_tx_arbiter.sv
// LUMI transmit arbiter
// Gates each channel with the local enable, PHY ready, serializer room
// and credit, gives a response priority over a request, drives the
// channel readies and hands the winning packet to the serializer
module lumi_tx_arbiter
   (input                       csr_en,        // Sending enabled
    input                       phy_txrdy,     // PHY takes a new packet
    input                       tx_free,       // Serializer can load
    input                       req_valid,
    input                       resp_valid,
    input                       req_crdt_ok,
    input                       resp_crdt_ok,
    input  lumi_pkg::umi_pkt_t  req_pkt,
    input  lumi_pkg::umi_pkt_t  resp_pkt,
    input  lumi_pkg::byte_cnt_t req_bytes,
    input  lumi_pkg::byte_cnt_t resp_bytes,
    output logic                req_ready,
    output logic                resp_ready,
    output logic                load,          // Serializer load strobe
    output logic                sel_resp,      // Loaded packet is a response
    output lumi_pkg::umi_pkt_t  pkt,
    output lumi_pkg::byte_cnt_t bytes
    );

   logic link_open;   // Local side can start a packet
   logic req_elig;
   logic resp_elig;

   // ########################################
   // Gating
   // ########################################
   assign link_open = csr_en & phy_txrdy & tx_free;
   assign req_elig  = link_open & req_valid & req_crdt_ok;
   assign resp_elig = link_open & resp_valid & resp_crdt_ok;

   // ########################################
   // Priority and packet select
   // ########################################
   always_comb
   begin
      resp_ready = resp_elig;               // Response always wins
      req_ready  = req_elig & ~resp_elig;
      load       = req_ready | resp_ready;
      sel_resp   = resp_elig;
      if (resp_elig)
      begin
         pkt   = resp_pkt;
         bytes = resp_bytes;
      end
      else
      begin
         pkt   = req_pkt;                   // Don't care unless load
         bytes = req_bytes;
      end
   end

endmodule

//--- lumi_tx_serializer.sv
// LUMI transmit serializer
// Holds one packet in a shift register with a byte-valid mask, sends
// io_w bits per cycle least significant byte first, and tells the
// arbiter when the next packet can load
module lumi_tx_serializer
  #(parameter int io_w = 64)  // PHY width in bits
   (input                       clk,
    input                       nreset,
    input                       load,        // Take pkt this cycle
    input                       sel_resp,    // pkt is a response
    input  lumi_pkg::umi_pkt_t  pkt,
    input  lumi_pkg::byte_cnt_t bytes,       // Valid bytes of pkt
    output logic                tx_free,     // Room for the next packet
    output logic                phy_txvld,
    output logic                beat_resp,   // Current beat is a response
    output logic [io_w-1:0]     phy_txdata
    );

   localparam int beat_bytes = io_w / 8;

   lumi_pkg::umi_pkt_t   shreg;       // Packet being sent
   lumi_pkg::byte_mask_t mask;        // Bytes still to send
   lumi_pkg::byte_mask_t mask_next;   // Mask after this beat
   lumi_pkg::byte_mask_t mask_start;  // Mask of a fresh packet

   // ########################################
   // Byte-valid mask
   // ########################################
   // Ones in the low bytes for each byte of the packet
   assign mask_start = ~({lumi_pkg::pkt_bytes{1'b1}} << bytes);
   assign mask_next  = mask >> beat_bytes;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         mask      <= '0;
         beat_resp <= 1'b0;
      end
      else if (load)
      begin
         mask      <= mask_start;
         beat_resp <= sel_resp;        // Channel for credit counting
      end
      else
         mask      <= mask_next;

   // ########################################
   // Data shift register
   // ########################################
   always_ff @(posedge clk)
      if (load)
         shreg <= pkt;
      else
         shreg <= lumi_pkg::umi_pkt_t'(shreg >> io_w);  // Next beat down

   // ########################################
   // PHY side
   // ########################################
   assign phy_txvld  = |mask;
   assign phy_txdata = shreg[io_w-1:0];

   // Idle or sending the last beat
   assign tx_free = ~|mask | ~|mask_next;

   // Arbiter never loads over a packet still in flight
   a_load_free: assert property (@(posedge clk) disable iff (!nreset)
      load |-> tx_free)
      else $error("serializer: load while a packet is still in flight");

endmodule

//--- lumi_tx.sv
// LUMI transmit top level
// Request and response UMI channels in, parallel PHY bus out. Decodes
// each channel's packet size, checks it against remote credit, picks a
// channel and serializes the packet io_w bits per cycle
module lumi_tx
  #(parameter int io_w = 64)  // PHY width, multiple of 8
   (input                      clk,
    input                      nreset,
    input                      csr_en,          // Enable sending
    // Request channel
    input                      req_valid,
    input  lumi_pkg::umi_pkt_t req_pkt,
    output logic               req_ready,
    // Response channel
    input                      resp_valid,
    input  lumi_pkg::umi_pkt_t resp_pkt,
    output logic               resp_ready,
    // PHY
    output logic [io_w-1:0]    phy_txdata,
    output logic               phy_txvld,
    input                      phy_txrdy,
    // Credits
    input  lumi_pkg::crdt_t    rmt_crdt_req,
    input  lumi_pkg::crdt_t    rmt_crdt_resp,
    output logic [31:0]        csr_crdt_status
    );

   lumi_pkg::byte_cnt_t req_bytes;
   lumi_pkg::byte_cnt_t resp_bytes;
   lumi_pkg::byte_cnt_t sel_bytes;
   lumi_pkg::beat_cnt_t req_beats;
   lumi_pkg::beat_cnt_t resp_beats;
   lumi_pkg::umi_pkt_t  sel_pkt;
   logic                req_crdt_ok;
   logic                resp_crdt_ok;
   logic                tx_free;
   logic                load;
   logic                sel_resp;
   logic                beat_resp;

   // ########################################
   // Size decode, one per channel
   // ########################################
   lumi_cmd_decode #(.io_w(io_w))
   u_dec_req (.cmd(req_pkt.cmd), .pkt_bytes(req_bytes), .beats(req_beats));

   lumi_cmd_decode #(.io_w(io_w))
   u_dec_resp (.cmd(resp_pkt.cmd), .pkt_bytes(resp_bytes), .beats(resp_beats));

   // Credit check and status
   lumi_tx_credit #(.io_w(io_w))
   u_credit (.clk(clk), .nreset(nreset),
             .rmt_crdt_req(rmt_crdt_req), .rmt_crdt_resp(rmt_crdt_resp),
             .req_beats(req_beats), .resp_beats(resp_beats),
             .req_valid(req_valid), .resp_valid(resp_valid),
             .phy_txrdy(phy_txrdy), .phy_txvld(phy_txvld), .beat_resp(beat_resp),
             .req_crdt_ok(req_crdt_ok), .resp_crdt_ok(resp_crdt_ok),
             .crdt_status(csr_crdt_status));

   // Channel select
   lumi_tx_arbiter
   u_arbiter (.csr_en(csr_en), .phy_txrdy(phy_txrdy), .tx_free(tx_free),
              .req_valid(req_valid), .resp_valid(resp_valid),
              .req_crdt_ok(req_crdt_ok), .resp_crdt_ok(resp_crdt_ok),
              .req_pkt(req_pkt), .resp_pkt(resp_pkt),
              .req_bytes(req_bytes), .resp_bytes(resp_bytes),
              .req_ready(req_ready), .resp_ready(resp_ready),
              .load(load), .sel_resp(sel_resp), .pkt(sel_pkt), .bytes(sel_bytes));

   // ########################################
   // Serializer to the PHY
   // ########################################
   lumi_tx_serializer #(.io_w(io_w))
   u_serializer (.clk(clk), .nreset(nreset),
                 .load(load), .sel_resp(sel_resp), .pkt(sel_pkt), .bytes(sel_bytes),
                 .tx_free(tx_free), .phy_txvld(phy_txvld), .beat_resp(beat_resp),
                 .phy_txdata(phy_txdata));

endmodule

//--- tb_lumi_tx.sv
// Testbench for the LUMI transmit block
// Sends request and response packets, models their byte and beat
// counts, collects the PHY beats and checks them with assertions
module tb_lumi_tx;

   localparam int io_w         = 64;
   localparam int beat_bytes   = io_w / 8;
   localparam int clk_period   = 20;
   localparam int reset_cycles = 5;
   localparam int pkt_budget   = 40;  // Cycles allowed for one packet
   localparam int n_rand       = 4;   // Random write requests
   localparam int hold_cycles  = 6;   // Stall and gating windows
   localparam int run_cycles   = reset_cycles + (n_rand + 5) * pkt_budget
                                 + 3 * hold_cycles + 50;

   logic               clk;
   logic               nreset;
   logic               csr_en;
   logic               req_valid;
   logic               resp_valid;
   logic               req_ready;
   logic               resp_ready;
   lumi_pkg::umi_pkt_t req_pkt;
   lumi_pkg::umi_pkt_t resp_pkt;
   logic [io_w-1:0]    phy_txdata;
   logic               phy_txvld;
   logic               phy_txrdy;
   lumi_pkg::crdt_t    rmt_crdt_req;
   lumi_pkg::crdt_t    rmt_crdt_resp;
   logic [31:0]        csr_crdt_status;

   logic [31:0]        lcg_state = 32'h487d5aaa;
   logic [io_w-1:0]    beat_q[$];         // Collected PHY words
   int                 cyc_q[$];          // Cycle of each word
   int                 cycle = 0;
   int                 errors = 0;
   int                 checks = 0;
   int                 n_tests = 0;
   int                 err_base = 0;
   int                 sent_req_m = 0;    // Request beats sent so far
   string              test_name = "reset";

   lumi_tx #(.io_w(io_w))
   u_dut (.clk(clk), .nreset(nreset), .csr_en(csr_en),
          .req_valid(req_valid), .req_pkt(req_pkt), .req_ready(req_ready),
          .resp_valid(resp_valid), .resp_pkt(resp_pkt), .resp_ready(resp_ready),
          .phy_txdata(phy_txdata), .phy_txvld(phy_txvld), .phy_txrdy(phy_txrdy),
          .rmt_crdt_req(rmt_crdt_req), .rmt_crdt_resp(rmt_crdt_resp),
          .csr_crdt_status(csr_crdt_status));

   always #(clk_period / 2) clk = ~clk;

   // ########################################
   // Beat monitor
   // ########################################
   always @(posedge clk) cycle <= cycle + 1;

   always @(negedge clk)
      if (phy_txvld)
      begin
         beat_q.push_back(phy_txdata);
         cyc_q.push_back(cycle);
      end

   // No ready while the link is closed locally
   a_gated: assert property (@(posedge clk) disable iff (!nreset)
      (!csr_en || !phy_txrdy) |-> !(req_ready || resp_ready))
      else
      begin
         $display("MISMATCH %s gated readies expected 00 actual %b%b", test_name,
                  $sampled(req_ready), $sampled(resp_ready));
         errors++;
      end

   // ########################################
   // Model and helpers
   // ########################################
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Wire bytes by packet class
   function automatic int model_bytes(input lumi_pkg::umi_cmd_t cmd);
      int data;
      case (cmd[4:0])
         lumi_pkg::op_invalid, lumi_pkg::op_link: return 4;   // Command only
         lumi_pkg::op_req_read, lumi_pkg::op_req_rdma, lumi_pkg::op_resp_write,
         lumi_pkg::op_user0, lumi_pkg::op_error: return 20;   // Header only
         default: ;
      endcase
      data = (int'(cmd[15:8]) + 1) << cmd[7:5];
      if (data > 16)
         data = 16;                                           // Payload limit
      return 20 + data;
   endfunction

   function automatic int model_beats(input int nbytes);
      return (nbytes + beat_bytes - 1) / beat_bytes;
   endfunction

   function automatic lumi_pkg::umi_pkt_t make_pkt(input logic [4:0] opcode,
                                                   input logic [7:0] len,
                                                   input logic [2:0] size);
      lumi_pkg::umi_pkt_t p;
      logic [31:0]        r;
      r         = next_random();
      p.cmd     = {r[31:16], len, size, opcode};
      p.dstaddr = {next_random(), next_random()};
      p.srcaddr = {next_random(), next_random()};
      p.data    = {next_random(), next_random(), next_random(), next_random()};
      return p;
   endfunction

   task automatic compare_value(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
      checks++;
      assert (exp === act)
      else
      begin
         $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_base  = errors;
      n_tests++;
   endtask

   task automatic end_test();
      $display("test %-14s done, %0d errors", test_name, errors - err_base);
   endtask

   // Negedge where the channel's ready is high, cycle returned in k
   task automatic wait_accept(input logic resp, output int k);
      k = -1;
      for (int n = 0; n < pkt_budget && k < 0; n++)
      begin
         @(negedge clk);
         if (resp ? resp_ready : req_ready)
            k = cycle;
      end
      if (k < 0)
      begin
         $display("%s: packet was never accepted", test_name);
         errors++;
      end
   endtask

   task automatic wait_idle();
      @(negedge clk);
      for (int n = 0; phy_txvld && n < pkt_budget; n++)
         @(negedge clk);
      if (phy_txvld)
      begin
         $display("%s: PHY kept sending past the packet budget", test_name);
         errors++;
      end
   endtask

   // Beats from index first, one per cycle from start_cyc, valid bytes only
   task automatic check_stream(input lumi_pkg::umi_pkt_t pkt, input int first,
                               input int start_cyc);
      logic [319:0]    bits;
      logic [io_w-1:0] keep;
      int              nbytes;
      int              nbeats;
      bits   = {32'b0, pkt};
      nbytes = model_bytes(pkt.cmd);
      nbeats = model_beats(nbytes);
      if (beat_q.size() < first + nbeats)
      begin
         $display("%s: only %0d beats on the PHY", test_name, beat_q.size());
         errors++;
         return;
      end
      for (int i = 0; i < nbeats; i++)
      begin
         keep = '0;
         for (int b = 0; b < beat_bytes; b++)
            if (i * beat_bytes + b < nbytes)
               keep[8*b +: 8] = 8'hff;
         compare_value("beat cycle", 64'(start_cyc + i), 64'(cyc_q[first + i]));
         compare_value("beat data", bits[io_w*i +: io_w] & keep, beat_q[first + i] & keep);
      end
   endtask

   // One packet on one channel, then its whole stream
   task automatic send_one(input logic resp, input lumi_pkg::umi_pkt_t pkt);
      int k;
      int nbeats;
      nbeats = model_beats(model_bytes(pkt.cmd));
      beat_q.delete();
      cyc_q.delete();
      @(posedge clk);
      if (resp)
      begin
         resp_valid <= 1'b1;
         resp_pkt   <= pkt;
      end
      else
      begin
         req_valid <= 1'b1;
         req_pkt   <= pkt;
      end
      wait_accept(resp, k);
      @(posedge clk);
      req_valid  <= 1'b0;
      resp_valid <= 1'b0;
      wait_idle();
      compare_value("beat count", 64'(nbeats), 64'(beat_q.size()));
      check_stream(pkt, 0, k + 1);
      if (!resp)
         sent_req_m += nbeats;
   endtask

   // ########################################
   // Watchdog
   // ########################################
   initial
   begin
      #(run_cycles * clk_period);
      $display("watchdog: run did not end within %0d cycles, stopping", run_cycles);
      $display("Something failed");
      $finish;
   end

   // ########################################
   // Tests
   // ########################################
   initial
   begin
      lumi_pkg::umi_pkt_t qp;
      lumi_pkg::umi_pkt_t rp;
      logic [31:0]        r;
      logic [31:0]        s0;
      int                 k_req;
      int                 k_resp;
      int                 nb_req;
      int                 nb_resp;

      clk           = 1'b0;
      nreset        = 1'b0;
      csr_en        = 1'b1;
      req_valid     = 1'b0;
      resp_valid    = 1'b0;
      req_pkt       = '0;
      resp_pkt      = '0;
      phy_txrdy     = 1'b1;
      rmt_crdt_req  = 16'hffff;
      rmt_crdt_resp = 16'hffff;
      repeat (reset_cycles) @(posedge clk);
      nreset <= 1'b1;

      start_test("reset");
      @(negedge clk);
      compare_value("phy_txvld", 64'd0, 64'(phy_txvld));
      compare_value("readies", 64'd0, 64'({req_ready, resp_ready}));
      compare_value("status", 64'd0, 64'(csr_crdt_status));
      end_test();

      start_test("full write");
      for (int i = 0; i < n_rand; i++)
      begin
         r = next_random();
         send_one(1'b0, make_pkt(lumi_pkg::op_req_write, {6'b0, r[1:0]}, {1'b0, r[4:3]}));
      end
      end_test();

      start_test("short packets");
      r = next_random();
      send_one(1'b0, make_pkt(lumi_pkg::op_req_read, r[7:0], r[10:8]));   // 3 beats
      send_one(1'b1, make_pkt(lumi_pkg::op_link, r[15:8], r[2:0]));       // 1 beat
      end_test();

      // Both valid together, response first then request back to back
      start_test("priority");
      r       = next_random();
      rp      = make_pkt(lumi_pkg::op_resp_read, {6'b0, r[1:0]}, 3'd1);
      qp      = make_pkt(lumi_pkg::op_req_posted, {6'b0, r[3:2]}, 3'd2);
      nb_resp = model_beats(model_bytes(rp.cmd));
      nb_req  = model_beats(model_bytes(qp.cmd));
      beat_q.delete();
      cyc_q.delete();
      @(posedge clk);
      req_valid  <= 1'b1;
      req_pkt    <= qp;
      resp_valid <= 1'b1;
      resp_pkt   <= rp;
      wait_accept(1'b1, k_resp);
      compare_value("request held", 64'd0, 64'(req_ready));
      @(posedge clk);
      resp_valid <= 1'b0;
      wait_accept(1'b0, k_req);
      @(posedge clk);
      req_valid <= 1'b0;
      wait_idle();
      compare_value("request accept cycle", 64'(k_resp + nb_resp), 64'(k_req));
      compare_value("beat count", 64'(nb_resp + nb_req), 64'(beat_q.size()));
      check_stream(rp, 0, k_resp + 1);
      check_stream(qp, nb_resp, k_req + 1);  // Right after the last response beat
      sent_req_m += nb_req;
      end_test();

      // Request limit one beat short of the cost
      start_test("credit block");
      qp     = make_pkt(lumi_pkg::op_req_write, 8'd3, 3'd2);                // Full, 5 beats
      nb_req = model_beats(model_bytes(qp.cmd));
      beat_q.delete();
      cyc_q.delete();
      @(posedge clk);
      rmt_crdt_req <= lumi_pkg::crdt_t'(sent_req_m + nb_req - 1);
      @(negedge clk);
      s0 = csr_crdt_status;
      @(posedge clk);
      req_valid <= 1'b1;
      req_pkt   <= qp;
      for (int i = 0; i < hold_cycles; i++)
      begin
         @(negedge clk);
         compare_value("request ready", 64'd0, 64'(req_ready));
         compare_value("request stalls", 64'(16'(s0[15:0] + i)), 64'(csr_crdt_status[15:0]));
         @(posedge clk);
      end
      rmt_crdt_req <= lumi_pkg::crdt_t'(sent_req_m + nb_req);           // Just enough
      wait_accept(1'b0, k_req);
      @(posedge clk);
      req_valid <= 1'b0;
      wait_idle();
      compare_value("beat count", 64'(nb_req), 64'(beat_q.size()));
      check_stream(qp, 0, k_req + 1);
      compare_value("final stalls", 64'(16'(s0[15:0] + hold_cycles)),
                    64'(csr_crdt_status[15:0]));
      sent_req_m += nb_req;
      end_test();

      start_test("local gating");
      qp = make_pkt(lumi_pkg::op_req_read, 8'd0, 3'd0);
      rp = make_pkt(lumi_pkg::op_resp_write, 8'd0, 3'd0);
      @(posedge clk);
      csr_en       <= 1'b0;
      req_valid    <= 1'b1;
      req_pkt      <= qp;
      resp_valid   <= 1'b1;
      resp_pkt     <= rp;
      rmt_crdt_req <= 16'hffff;
      for (int i = 0; i < hold_cycles; i++)
      begin
         @(negedge clk);
         compare_value("readies, csr_en low", 64'd0, 64'({req_ready, resp_ready}));
      end
      @(posedge clk);
      csr_en       <= 1'b1;
      phy_txrdy    <= 1'b0;
      rmt_crdt_req <= lumi_pkg::crdt_t'(sent_req_m);   // No request credit left
      @(negedge clk);
      s0 = csr_crdt_status;
      for (int i = 0; i < hold_cycles; i++)
      begin
         @(negedge clk);
         compare_value("readies, PHY busy", 64'd0, 64'({req_ready, resp_ready}));
         compare_value("status, PHY busy", 64'(s0), 64'(csr_crdt_status));
      end
      @(posedge clk);
      req_valid    <= 1'b0;
      resp_valid   <= 1'b0;
      phy_txrdy    <= 1'b1;
      rmt_crdt_req <= 16'hffff;
      @(negedge clk);
      compare_value("status after", 64'(s0), 64'(csr_crdt_status));
      end_test();

      $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

//--- tb.f
lumi_pkg.sv
lumi_cmd_decode.sv
lumi_tx_credit.sv
lumi_tx_arbiter.sv
lumi_tx_serializer.sv
lumi_tx.sv
tb_lumi_tx.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_lumi_tx
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_TEXT = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
